// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_ipv4_pkt_gen
FILELIST  ?= ipv4_pkt_gen.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== ipv4_frame_builder.sv ====
/* Serialises one Ethernet/IPv4 frame per request as a byte stream with valid, ready
   and last. Header fields are latched at the request, the payload repeats the packet id. */
`timescale 1ns/1ns

module ipv4_frame_builder (
    input  logic                      clk_ifc_avmm,
    input  logic                      rst_n,
    input  logic                      frame_req,
    input  logic [31:0]               packet_id,
    input  pkt_gen_pkg::ip_hdr_cfg_t  hdr_cfg,
    output logic [7:0]                tdata,
    output logic                      tvalid,
    input  logic                      tready,
    output logic                      tlast,
    output logic                      frame_done
);

    pkt_gen_pkg::ip_hdr_cfg_t                hdr_q;
    logic [31:0]                             pid_q;
    logic [15:0]                             csum_q;
    logic [pkt_gen_pkg::BYTE_CNT_W-1:0]      byte_cnt;
    logic [pkt_gen_pkg::HDR_BYTES*8-1:0]     hdr_vec;
    logic [1:0]                              pay_lane;
    logic [19:0]                             csum_sum;
    logic [16:0]                             csum_fold;
    logic [15:0]                             csum_calc;
    logic                                    accept;

    //////////////////////////////////////////////////
    // IPv4 header checksum

    // Ones'-complement sum of the header words, checksum word taken as zero
    always_comb begin
        csum_sum = 20'({pkt_gen_pkg::IP_VER_IHL, hdr_cfg.dscp, hdr_cfg.ecn})
                 + 20'(pkt_gen_pkg::IP_TOTAL_LEN)
                 + 20'(hdr_cfg.identification)
                 + 20'({pkt_gen_pkg::IP_FLAGS_DF, 13'd0})
                 + 20'({hdr_cfg.ttl, hdr_cfg.protocol})
                 + 20'(hdr_cfg.src_ip[31:16])
                 + 20'(hdr_cfg.src_ip[15:0])
                 + 20'(hdr_cfg.dst_ip[31:16])
                 + 20'(hdr_cfg.dst_ip[15:0]);
        csum_fold = 17'(csum_sum[15:0]) + 17'(csum_sum[19:16]);
        csum_calc = ~(csum_fold[15:0] + 16'(csum_fold[16]));   // Second fold, then invert
    end

    // Latched at the request so the frame is stable against register writes
    always_ff @(posedge clk_ifc_avmm) begin
        if (frame_req) begin
            hdr_q  <= hdr_cfg;
            pid_q  <= packet_id;
            csum_q <= csum_calc;
        end
    end

    //////////////////////////////////////////////////
    // Byte selection

    // Both headers in network order, first byte in the top lane
    assign hdr_vec = {
        hdr_q.dst_mac,
        pkt_gen_pkg::SRC_MAC,
        pkt_gen_pkg::ETH_TYPE_IPV4,
        pkt_gen_pkg::IP_VER_IHL,
        hdr_q.dscp,
        hdr_q.ecn,
        pkt_gen_pkg::IP_TOTAL_LEN,
        hdr_q.identification,
        pkt_gen_pkg::IP_FLAGS_DF,
        13'd0,                                  // Fragment offset
        hdr_q.ttl,
        hdr_q.protocol,
        csum_q,
        hdr_q.src_ip,
        hdr_q.dst_ip
    };

    assign pay_lane = 2'(byte_cnt - pkt_gen_pkg::BYTE_CNT_W'(pkt_gen_pkg::HDR_BYTES));

    always_comb begin
        if (byte_cnt < pkt_gen_pkg::BYTE_CNT_W'(pkt_gen_pkg::HDR_BYTES)) begin
            tdata = hdr_vec[(pkt_gen_pkg::HDR_BYTES - 1 - byte_cnt) * 8 +: 8];
        end else begin
            tdata = pid_q[(3 - pay_lane) * 8 +: 8];  // Big-endian payload word
        end
    end

    //////////////////////////////////////////////////
    // Stream control

    assign accept     = tvalid && tready;
    assign tlast      = tvalid
                     && (byte_cnt == pkt_gen_pkg::BYTE_CNT_W'(pkt_gen_pkg::FRAME_BYTES - 1));
    assign frame_done = accept && tlast;

    always_ff @(posedge clk_ifc_avmm or negedge rst_n) begin
        if (!rst_n) begin
            tvalid   <= 1'b0;
            byte_cnt <= '0;
        end else if (frame_req) begin
            tvalid   <= 1'b1;
            byte_cnt <= '0;
        end else if (accept) begin
            if (tlast) begin
                tvalid   <= 1'b0;
                byte_cnt <= '0;
            end else begin
                byte_cnt <= byte_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== ipv4_pkt_gen.f ====
pkt_gen_pkg.sv
pkt_gen_regs.sv
pkt_gen_sequencer.sv
ipv4_frame_builder.sv
ipv4_pkt_gen.sv
pkt_gen_assertions.sv
pkt_gen_checker.sv
tb_ipv4_pkt_gen.sv

// ==== ipv4_pkt_gen.sv ====
/* Top level of the IPv4/UDP test-frame generator. Connects the register bank,
   the send sequencer and the frame builder. */
`timescale 1ns/1ns

module ipv4_pkt_gen (
    input  logic                    clk_ifc_avmm,
    input  logic                    rst_n,
    input  pkt_gen_pkg::avmm_req_t  avmm_req,
    output logic [31:0]             readdata,
    output logic                    readdatavalid,
    output logic [7:0]              tdata,
    output logic                    tvalid,
    input  logic                    tready,
    output logic                    tlast
);

    pkt_gen_pkg::seq_cfg_t     seq_cfg;
    pkt_gen_pkg::ip_hdr_cfg_t  hdr_cfg;
    pkt_gen_pkg::seq_state_t   state;
    logic                      start;
    logic                      frame_req;
    logic                      frame_done;
    logic [31:0]               packet_id;
    logic [31:0]               remaining;
    logic [31:0]               sent_count;

    pkt_gen_regs u_regs (
        .clk_ifc_avmm  (clk_ifc_avmm),
        .rst_n         (rst_n),
        .avmm_req      (avmm_req),
        .readdata      (readdata),
        .readdatavalid (readdatavalid),
        .seq_cfg       (seq_cfg),
        .start         (start),
        .hdr_cfg       (hdr_cfg),
        .state         (state),
        .remaining     (remaining),
        .sent_count    (sent_count)
    );

    pkt_gen_sequencer u_sequencer (
        .clk_ifc_avmm (clk_ifc_avmm),
        .rst_n        (rst_n),
        .seq_cfg      (seq_cfg),
        .start        (start),
        .frame_done   (frame_done),
        .frame_req    (frame_req),
        .packet_id    (packet_id),
        .state        (state),
        .remaining    (remaining),
        .sent_count   (sent_count)
    );

    ipv4_frame_builder u_builder (
        .clk_ifc_avmm (clk_ifc_avmm),
        .rst_n        (rst_n),
        .frame_req    (frame_req),
        .packet_id    (packet_id),
        .hdr_cfg      (hdr_cfg),
        .tdata        (tdata),
        .tvalid       (tvalid),
        .tready       (tready),
        .tlast        (tlast),
        .frame_done   (frame_done)
    );

endmodule

// ==== pkt_gen_assertions.sv ====
/* Protocol assertions on the output stream and the Avalon-MM read timing,
   bound into the generator top level. */
`timescale 1ns/1ns

module pkt_gen_assertions (
    input logic                    clk_ifc_avmm,
    input logic                    rst_n,
    input pkt_gen_pkg::avmm_req_t  avmm_req,
    input logic                    readdatavalid,
    input logic [7:0]              tdata,
    input logic                    tvalid,
    input logic                    tready,
    input logic                    tlast
);

    // Stalled beat holds
    a_stream_hold: assert property (@(posedge clk_ifc_avmm) disable iff (!rst_n)
        tvalid && !tready |=> tvalid && $stable(tdata))
        else $error("stream beat changed under back-pressure");

    a_read_latency: assert property (@(posedge clk_ifc_avmm) disable iff (!rst_n)
        avmm_req.read |=> readdatavalid)
        else $error("readdatavalid missing one cycle after a read");

    a_no_spurious_rdv: assert property (@(posedge clk_ifc_avmm) disable iff (!rst_n)
        readdatavalid |-> $past(avmm_req.read))
        else $error("readdatavalid without a read");

    // Accepted last beat closes the frame
    a_last_ends_frame: assert property (@(posedge clk_ifc_avmm) disable iff (!rst_n)
        tlast && tready |=> !tvalid)
        else $error("stream still valid after the accepted last beat");

endmodule

bind ipv4_pkt_gen pkt_gen_assertions u_assertions (.*);

// ==== pkt_gen_checker.sv ====
/* Testbench monitor. Rebuilds each expected frame from the programmed fields and the
   expected packet id, compares the stream and the register reads, and scores each test. */
`timescale 1ns/1ns

module pkt_gen_checker (
    input  logic                      clk_ifc_avmm,
    input  logic                      rst_n,
    input  logic [7:0]                tdata,
    input  logic                      tvalid,
    input  logic                      tready,
    input  logic                      tlast,
    input  logic [31:0]               readdata,
    input  logic                      readdatavalid,
    input  pkt_gen_pkg::ip_hdr_cfg_t  exp_hdr,
    input  logic [31:0]               exp_rd,
    input  logic                      exp_rd_en,
    input  logic                      test_begin,
    input  logic                      test_end,
    input  logic [31:0]               exp_frames,
    input  logic                      cont_mode,
    output logic [31:0]               frames_seen,
    output int                        error_count,
    output int                        tests_passed,
    output int                        tests_failed
);

    int          byte_idx;
    int          test_errs;
    int          test_num;
    logic [31:0] next_id;

    // Ones'-complement sum over the ten header words, checksum word as zero
    function automatic logic [15:0] ip_checksum(input pkt_gen_pkg::ip_hdr_cfg_t h);
        logic [31:0] sum;
        sum = 32'h4500 + {h.dscp, h.ecn} + 32'd52 + h.identification + 32'h4000
            + {h.ttl, h.protocol} + h.src_ip[31:16] + h.src_ip[15:0]
            + h.dst_ip[31:16] + h.dst_ip[15:0];
        while (sum[31:16] != 0) begin
            sum = sum[15:0] + sum[31:16];
        end
        return ~sum[15:0];
    endfunction

    function automatic logic [7:0] frame_byte(input pkt_gen_pkg::ip_hdr_cfg_t h, input int idx,
                                              input logic [31:0] pid);
        logic [271:0] hdr;
        hdr = {h.dst_mac, pkt_gen_pkg::SRC_MAC, 16'h0800, 8'h45, h.dscp, h.ecn, 16'd52,
               h.identification, 16'h4000, h.ttl, h.protocol, ip_checksum(h),
               h.src_ip, h.dst_ip};
        if (idx < 34) begin
            return hdr[(33 - idx) * 8 +: 8];
        end
        return pid[(3 - (idx - 34) % 4) * 8 +: 8];
    endfunction

    always @(posedge clk_ifc_avmm or negedge rst_n) begin
        if (!rst_n) begin
            frames_seen  = '0;
            error_count  = 0;
            tests_passed = 0;
            tests_failed = 0;
            byte_idx     = 0;
            test_errs    = 0;
            test_num     = 0;
            next_id      = '0;
        end else begin
            if (test_begin) begin
                frames_seen = '0;
                byte_idx    = 0;
                next_id     = '0;
                test_errs   = 0;
                test_num    = test_num + 1;
            end
            if (tvalid && tready) begin
                if (tdata !== frame_byte(exp_hdr, byte_idx, next_id)) begin
                    $display("[ERROR] %0t: frame %0d byte %0d is %h, expected %h", $time,
                             frames_seen, byte_idx, tdata, frame_byte(exp_hdr, byte_idx, next_id));
                    test_errs = test_errs + 1;
                end
                if (tlast !== (byte_idx == pkt_gen_pkg::FRAME_BYTES - 1)) begin
                    $display("[ERROR] %0t: tlast is %b at byte %0d", $time, tlast, byte_idx);
                    test_errs = test_errs + 1;
                end
                if (tlast || byte_idx == pkt_gen_pkg::FRAME_BYTES - 1) begin
                    byte_idx    = 0;
                    frames_seen = frames_seen + 1;
                    next_id     = next_id + 1;
                end else begin
                    byte_idx = byte_idx + 1;
                end
            end
            if (readdatavalid && exp_rd_en && readdata !== exp_rd) begin
                $display("[ERROR] %0t: read data %h, expected %h", $time, readdata, exp_rd);
                test_errs = test_errs + 1;
            end
            if (test_end) begin
                // Continuous runs may finish one frame past the stop point
                if (cont_mode && exp_frames != 0 ? frames_seen < exp_frames
                                                 : frames_seen != exp_frames) begin
                    $display("[ERROR] %0t: %0d frames seen, expected %0d", $time,
                             frames_seen, exp_frames);
                    test_errs = test_errs + 1;
                end
                if (test_errs == 0) begin
                    $display("Test %0d: ok, %0d frames", test_num, frames_seen);
                    tests_passed = tests_passed + 1;
                end else begin
                    $display("Test %0d: %0d errors, %0d frames", test_num, test_errs,
                             frames_seen);
                    tests_failed = tests_failed + 1;
                end
                error_count = error_count + test_errs;
                test_errs   = 0;
            end
        end
    end

endmodule

// ==== pkt_gen_pkg.sv ====
/* Shared constants, register map and struct types of the IPv4/UDP test-frame generator.
   Every design file refers to these by scoped name. */
package pkt_gen_pkg;

    //////////////////////////////////////////////////
    // Frame geometry

    localparam int PAYLOAD_WORDS = 8;                   // 32-bit payload words per frame
    localparam int ETH_HDR_BYTES = 14;
    localparam int IP_HDR_BYTES  = 20;
    localparam int HDR_BYTES     = ETH_HDR_BYTES + IP_HDR_BYTES;
    localparam int FRAME_BYTES   = HDR_BYTES + 4 * PAYLOAD_WORDS;
    localparam int BYTE_CNT_W    = $clog2(FRAME_BYTES);

    // Shaper charge per frame, frame length in the 16.16 format
    localparam logic [31:0] SHAPER_CHARGE = 32'(FRAME_BYTES) << 16;

    //////////////////////////////////////////////////
    // Fixed header fields

    localparam logic [15:0] IP_TOTAL_LEN  = 16'(IP_HDR_BYTES + 4 * PAYLOAD_WORDS);
    localparam logic [47:0] SRC_MAC       = 48'haa_aa_aa_aa_bb_aa;
    localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
    localparam logic [7:0]  IP_VER_IHL    = 8'h45;      // Version 4, five header words
    localparam logic [2:0]  IP_FLAGS_DF   = 3'b010;     // Don't fragment

    //////////////////////////////////////////////////
    // Register map

    localparam logic [3:0] REG_CTRL       = 4'd0;       // bit0 start, bit1 continuous
    localparam logic [3:0] REG_NUM_PKTS   = 4'd1;
    localparam logic [3:0] REG_SHAPER_DEC = 4'd2;       // 15.16 decrement per cycle
    localparam logic [3:0] REG_DSCP_ECN   = 4'd3;       // dscp in 7:2, ecn in 1:0
    localparam logic [3:0] REG_IDENT      = 4'd4;
    localparam logic [3:0] REG_TTL_PROTO  = 4'd5;       // ttl in 15:8, protocol in 7:0
    localparam logic [3:0] REG_SRC_IP     = 4'd6;
    localparam logic [3:0] REG_DST_IP     = 4'd7;
    localparam logic [3:0] REG_DST_MAC_HI = 4'd8;
    localparam logic [3:0] REG_DST_MAC_LO = 4'd9;
    localparam logic [3:0] REG_STATUS     = 4'd10;      // Read only
    localparam logic [3:0] REG_SENT       = 4'd11;      // Read only
    localparam logic [3:0] REG_REMAINING  = 4'd12;      // Read only, frames left in a run

    //////////////////////////////////////////////////
    // Types

    typedef struct packed {
        logic [3:0]  address;
        logic        write;
        logic        read;
        logic [31:0] writedata;
    } avmm_req_t;

    typedef struct packed {
        logic [5:0]  dscp;
        logic [1:0]  ecn;
        logic [15:0] identification;
        logic [7:0]  ttl;
        logic [7:0]  protocol;
        logic [31:0] src_ip;
        logic [31:0] dst_ip;
        logic [47:0] dst_mac;
    } ip_hdr_cfg_t;

    typedef struct packed {
        logic [31:0] num_packets;
        logic        continuous;
        logic [30:0] shaper_dec;
    } seq_cfg_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_HEADER,
        ST_SEND,
        ST_WAIT_DONE
    } seq_state_t;

endpackage

// ==== pkt_gen_regs.sv ====
/* Avalon-MM register bank of the frame generator. Holds the header and run settings,
   raises the start strobe and returns read data one cycle after each read. */
`timescale 1ns/1ns

module pkt_gen_regs (
    input  logic                      clk_ifc_avmm,
    input  logic                      rst_n,
    input  pkt_gen_pkg::avmm_req_t    avmm_req,
    output logic [31:0]               readdata,
    output logic                      readdatavalid,
    output pkt_gen_pkg::seq_cfg_t     seq_cfg,
    output logic                      start,
    output pkt_gen_pkg::ip_hdr_cfg_t  hdr_cfg,
    input  pkt_gen_pkg::seq_state_t   state,
    input  logic [31:0]               remaining,
    input  logic [31:0]               sent_count
);

    logic        wr_ctrl;
    logic [31:0] rd_mux;
    logic [31:0] status_word;

    assign wr_ctrl = avmm_req.write && (avmm_req.address == pkt_gen_pkg::REG_CTRL);
    assign start   = wr_ctrl && avmm_req.writedata[0];   // Same cycle as the write

    assign status_word = {state != pkt_gen_pkg::ST_IDLE, 29'd0, state};

    //////////////////////////////////////////////////
    // Write decode

    always_ff @(posedge clk_ifc_avmm or negedge rst_n) begin
        if (!rst_n) begin
            seq_cfg <= '0;
            hdr_cfg <= '0;
        end else if (avmm_req.write) begin
            case (avmm_req.address)
                pkt_gen_pkg::REG_CTRL:       seq_cfg.continuous  <= avmm_req.writedata[1];
                pkt_gen_pkg::REG_NUM_PKTS:   seq_cfg.num_packets <= avmm_req.writedata;
                pkt_gen_pkg::REG_SHAPER_DEC: seq_cfg.shaper_dec  <= avmm_req.writedata[30:0];
                pkt_gen_pkg::REG_DSCP_ECN: begin
                    hdr_cfg.dscp <= avmm_req.writedata[7:2];
                    hdr_cfg.ecn  <= avmm_req.writedata[1:0];
                end
                pkt_gen_pkg::REG_IDENT:      hdr_cfg.identification <= avmm_req.writedata[15:0];
                pkt_gen_pkg::REG_TTL_PROTO: begin
                    hdr_cfg.ttl      <= avmm_req.writedata[15:8];
                    hdr_cfg.protocol <= avmm_req.writedata[7:0];
                end
                pkt_gen_pkg::REG_SRC_IP:     hdr_cfg.src_ip <= avmm_req.writedata;
                pkt_gen_pkg::REG_DST_IP:     hdr_cfg.dst_ip <= avmm_req.writedata;
                pkt_gen_pkg::REG_DST_MAC_HI: hdr_cfg.dst_mac[47:32] <= avmm_req.writedata[15:0];
                pkt_gen_pkg::REG_DST_MAC_LO: hdr_cfg.dst_mac[31:0]  <= avmm_req.writedata;
                default: ;                                   // Read-only and unused addresses
            endcase
        end
    end

    //////////////////////////////////////////////////
    // Read mux

    always_comb begin
        case (avmm_req.address)
            pkt_gen_pkg::REG_CTRL:       rd_mux = {30'd0, seq_cfg.continuous, 1'b0};
            pkt_gen_pkg::REG_NUM_PKTS:   rd_mux = seq_cfg.num_packets;
            pkt_gen_pkg::REG_SHAPER_DEC: rd_mux = {1'b0, seq_cfg.shaper_dec};
            pkt_gen_pkg::REG_DSCP_ECN:   rd_mux = {24'd0, hdr_cfg.dscp, hdr_cfg.ecn};
            pkt_gen_pkg::REG_IDENT:      rd_mux = {16'd0, hdr_cfg.identification};
            pkt_gen_pkg::REG_TTL_PROTO:  rd_mux = {16'd0, hdr_cfg.ttl, hdr_cfg.protocol};
            pkt_gen_pkg::REG_SRC_IP:     rd_mux = hdr_cfg.src_ip;
            pkt_gen_pkg::REG_DST_IP:     rd_mux = hdr_cfg.dst_ip;
            pkt_gen_pkg::REG_DST_MAC_HI: rd_mux = {16'd0, hdr_cfg.dst_mac[47:32]};
            pkt_gen_pkg::REG_DST_MAC_LO: rd_mux = hdr_cfg.dst_mac[31:0];
            pkt_gen_pkg::REG_STATUS:     rd_mux = status_word;
            pkt_gen_pkg::REG_SENT:       rd_mux = sent_count;
            pkt_gen_pkg::REG_REMAINING:  rd_mux = remaining;
            default:                     rd_mux = 32'd0;
        endcase
    end

    always_ff @(posedge clk_ifc_avmm or negedge rst_n) begin
        if (!rst_n) begin
            readdata      <= 32'd0;
            readdatavalid <= 1'b0;
        end else begin
            readdatavalid <= avmm_req.read;
            if (avmm_req.read) begin
                readdata <= rd_mux;
            end
        end
    end

endmodule

// ==== pkt_gen_sequencer.sv ====
/* Send sequencer. Runs counted or continuous sending, numbers the frames and
   paces continuous mode with a signed 16.16 leaky-bucket shaper. */
`timescale 1ns/1ns

module pkt_gen_sequencer (
    input  logic                     clk_ifc_avmm,
    input  logic                     rst_n,
    input  pkt_gen_pkg::seq_cfg_t    seq_cfg,
    input  logic                     start,
    input  logic                     frame_done,
    output logic                     frame_req,
    output logic [31:0]              packet_id,
    output pkt_gen_pkg::seq_state_t  state,
    output logic [31:0]              remaining,
    output logic [31:0]              sent_count
);

    logic [31:0] shaper_accum;                  // Signed 16.16
    logic [32:0] shaper_sum;
    logic [31:0] shaper_next;
    logic        shaper_negative;

    assign shaper_negative = shaper_accum[31];

    //////////////////////////////////////////////////
    // Shaper

    // One extra bit catches overflow of the 32-bit range in either direction
    always_comb begin
        if (frame_req) begin
            shaper_sum = {shaper_accum[31], shaper_accum} + {1'b0, pkt_gen_pkg::SHAPER_CHARGE};
        end else begin
            shaper_sum = {shaper_accum[31], shaper_accum} - {2'b00, seq_cfg.shaper_dec};
        end

        if (shaper_sum[32] == shaper_sum[31]) begin
            shaper_next = shaper_sum[31:0];
        end else if (shaper_sum[32]) begin
            shaper_next = 32'h8000_0000;        // Floor at most negative
        end else begin
            shaper_next = 32'h7fff_ffff;
        end
    end

    always_ff @(posedge clk_ifc_avmm or negedge rst_n) begin
        if (!rst_n) begin
            shaper_accum <= 32'd0;
        end else if (state == pkt_gen_pkg::ST_IDLE) begin
            shaper_accum <= 32'd0;
        end else begin
            shaper_accum <= shaper_next;
        end
    end

    //////////////////////////////////////////////////
    // Send FSM

    always_ff @(posedge clk_ifc_avmm or negedge rst_n) begin
        if (!rst_n) begin
            state      <= pkt_gen_pkg::ST_IDLE;
            frame_req  <= 1'b0;
            packet_id  <= 32'd0;
            remaining  <= 32'd0;
            sent_count <= 32'd0;
        end else begin
            frame_req <= 1'b0;
            case (state)
                pkt_gen_pkg::ST_IDLE: begin
                    if (start) begin
                        packet_id  <= 32'd0;
                        remaining  <= seq_cfg.num_packets;
                        sent_count <= 32'd0;
                        state      <= pkt_gen_pkg::ST_WAIT_HEADER;
                    end
                end

                pkt_gen_pkg::ST_WAIT_HEADER: begin
                    if (seq_cfg.continuous) begin
                        remaining <= 32'd0;             // Zero count marks a continuous run
                        if (shaper_negative) begin
                            frame_req <= 1'b1;
                            state     <= pkt_gen_pkg::ST_SEND;
                        end
                    end else if (remaining == 32'd0) begin
                        state <= pkt_gen_pkg::ST_IDLE;  // Count reached or continuous stopped
                    end else begin
                        frame_req <= 1'b1;
                        state     <= pkt_gen_pkg::ST_SEND;
                    end
                end

                // Builder latches the id on this edge
                pkt_gen_pkg::ST_SEND: begin
                    packet_id <= packet_id + 32'd1;
                    if (remaining != 32'd0) begin
                        remaining <= remaining - 32'd1;
                    end
                    state <= pkt_gen_pkg::ST_WAIT_DONE;
                end

                pkt_gen_pkg::ST_WAIT_DONE: begin
                    if (frame_done) begin
                        if (sent_count != 32'hffff_ffff) begin
                            sent_count <= sent_count + 32'd1;
                        end
                        state <= pkt_gen_pkg::ST_WAIT_HEADER;
                    end
                end

                default: state <= pkt_gen_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

// ==== pkt_gen_stim.txt ====
// First word: number of tests. Then one test per line, hex words:
// mode(0 counted,1 cont) ready(0 on,1 rand,2 alt) frames dscp_ecn ident ttl_proto src_ip dst_ip mac_hi mac_lo shaper_dec
5
0 0 3 b8 1234 4011 c0a80001 c0a80002 0012 3456789a 0
0 1 4 2d abcd 8011 0a000001 0a0000fe 0200 00000001 0
0 2 1 ff ffff ff11 ffffffff ffffffff ffff ffffffff 0
1 0 0 00 0001 4011 01020304 05060708 0a0b 0c0d0e0f 0
1 1 3 48 5555 2011 ac100001 ac100002 00aa bbccddee 100000

// ==== tb_ipv4_pkt_gen.sv ====
/* Testbench top for the IPv4 frame generator. Reads the test list from the stim file,
   programs the registers over Avalon-MM, runs each test and bounds the run with a timeout. */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk
);
    initial clk = 1'b0;
    always #2 clk = ~clk;                         // 4 ns period
endmodule

module tb_ipv4_pkt_gen;

    localparam int REC_WORDS = 11;                // Words per test record in the stim file

    logic                    clk_ifc_avmm;
    logic                    rst_n;
    pkt_gen_pkg::avmm_req_t  avmm_req;
    logic [31:0]             readdata;
    logic                    readdatavalid;
    logic [7:0]              tdata;
    logic                    tvalid;
    logic                    tready;
    logic                    tlast;

    pkt_gen_pkg::ip_hdr_cfg_t exp_hdr;
    logic [31:0] exp_rd;
    logic        exp_rd_en;
    logic        test_begin;
    logic        test_end;
    logic [31:0] exp_frames;
    logic        cont_mode;
    logic [31:0] frames_seen;
    int          error_count;
    int          tests_passed;
    int          tests_failed;

    logic [31:0] stim [0:255];
    int          ready_mode;
    int          cycles;
    int          cycle_limit;

    tb_clock_gen u_clk (.clk(clk_ifc_avmm));

    ipv4_pkt_gen dut (.*);

    pkt_gen_checker u_checker (.*);

    //////////////////////////////////////////////////
    // Bus helpers

    task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
        @(posedge clk_ifc_avmm);
        #1;
        avmm_req.address   = addr;
        avmm_req.writedata = data;
        avmm_req.write     = 1'b1;
        @(posedge clk_ifc_avmm);
        #1;
        avmm_req.write = 1'b0;
    endtask

    // Checked read when check is set, otherwise a poll that returns the value
    task automatic bus_read(input logic [3:0] addr, input logic check, input logic [31:0] exp,
                            output logic [31:0] value);
        @(posedge clk_ifc_avmm);
        #1;
        exp_rd_en        = check;
        exp_rd           = exp;
        avmm_req.address = addr;
        avmm_req.read    = 1'b1;
        @(posedge clk_ifc_avmm);
        #1;
        avmm_req.read = 1'b0;
        value         = readdata;
    endtask

    // One-cycle strobe on the begin or end marker of the checker
    task automatic strobe_marker(input logic at_end);
        @(posedge clk_ifc_avmm);
        #1;
        if (at_end) begin
            test_end = 1'b1;
        end else begin
            test_begin = 1'b1;
        end
        @(posedge clk_ifc_avmm);
        #1;
        test_begin = 1'b0;
        test_end   = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        st = 32'h8000_0000;
        while (st[31]) begin                        // Busy bit
            bus_read(pkt_gen_pkg::REG_STATUS, 1'b0, 32'd0, st);
        end
    endtask

    //////////////////////////////////////////////////
    // Sink back-pressure

    always @(posedge clk_ifc_avmm) begin
        #1;
        case (ready_mode)
            1:       tready = ($urandom % 4) != 0;
            2:       tready = ~tready;              // Every other cycle
            default: tready = 1'b1;
        endcase
    end

    // Timeout
    always @(posedge clk_ifc_avmm) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Test sequence

    initial begin
        int          n_tests;
        int          base;
        int          total_bytes;
        logic [31:0] rd;
        logic [31:0] n;

        void'($urandom(32'hc07d_c6e7));
        avmm_req    = '0;
        tready      = 1'b1;
        ready_mode  = 0;
        exp_hdr     = '0;
        exp_rd      = '0;
        exp_rd_en   = 1'b0;
        test_begin  = 1'b0;
        test_end    = 1'b0;
        exp_frames  = '0;
        cont_mode   = 1'b0;
        cycles      = 0;
        cycle_limit = 1000000;
        rst_n       = 1'b0;

        $readmemh("pkt_gen_stim.txt", stim);
        n_tests     = stim[0];
        total_bytes = 0;
        for (int t = 0; t < n_tests; t++) begin
            base        = 1 + t * REC_WORDS;
            total_bytes += (stim[base + 2] + stim[base]) * pkt_gen_pkg::FRAME_BYTES;
        end
        cycle_limit = total_bytes * 4 + 2000;

        repeat (16) @(posedge clk_ifc_avmm);
        #1;
        rst_n = 1'b1;

        for (int t = 0; t < n_tests; t++) begin
            base       = 1 + t * REC_WORDS;
            n          = stim[base + 2];
            cont_mode  = stim[base][0];
            exp_frames = n;
            exp_hdr.dscp           = stim[base + 3][7:2];
            exp_hdr.ecn            = stim[base + 3][1:0];
            exp_hdr.identification = stim[base + 4][15:0];
            exp_hdr.ttl            = stim[base + 5][15:8];
            exp_hdr.protocol       = stim[base + 5][7:0];
            exp_hdr.src_ip         = stim[base + 6];
            exp_hdr.dst_ip         = stim[base + 7];
            exp_hdr.dst_mac        = {stim[base + 8][15:0], stim[base + 9]};
            strobe_marker(1'b0);

            // Program registers 1 to 9 from the record, then read them back
            bus_write(pkt_gen_pkg::REG_NUM_PKTS, n);
            bus_write(pkt_gen_pkg::REG_SHAPER_DEC, stim[base + 10]);
            for (int r = 3; r <= 9; r++) begin
                bus_write(4'(r), stim[base + r]);
            end
            bus_read(pkt_gen_pkg::REG_NUM_PKTS, 1'b1, n, rd);
            bus_read(pkt_gen_pkg::REG_SHAPER_DEC, 1'b1, stim[base + 10] & 32'h7fff_ffff, rd);
            bus_read(pkt_gen_pkg::REG_DSCP_ECN, 1'b1, stim[base + 3] & 32'hff, rd);
            bus_read(pkt_gen_pkg::REG_IDENT, 1'b1, stim[base + 4] & 32'hffff, rd);
            bus_read(pkt_gen_pkg::REG_TTL_PROTO, 1'b1, stim[base + 5] & 32'hffff, rd);
            bus_read(pkt_gen_pkg::REG_SRC_IP, 1'b1, stim[base + 6], rd);
            bus_read(pkt_gen_pkg::REG_DST_IP, 1'b1, stim[base + 7], rd);
            bus_read(pkt_gen_pkg::REG_DST_MAC_HI, 1'b1, stim[base + 8] & 32'hffff, rd);
            bus_read(pkt_gen_pkg::REG_DST_MAC_LO, 1'b1, stim[base + 9], rd);

            ready_mode = stim[base + 1];
            if (cont_mode) begin
                bus_write(pkt_gen_pkg::REG_CTRL, 32'h3);
                if (n == 0) begin
                    repeat (200) @(posedge clk_ifc_avmm);
                end else begin
                    while (frames_seen < n) begin
                        @(posedge clk_ifc_avmm);
                        #1;
                    end
                end
                bus_write(pkt_gen_pkg::REG_CTRL, 32'h0);   // Stop after the frame in flight
            end else begin
                bus_write(pkt_gen_pkg::REG_CTRL, 32'h1);
                while (frames_seen < n) begin
                    @(posedge clk_ifc_avmm);
                    #1;
                end
            end
            wait_idle();
            bus_read(pkt_gen_pkg::REG_STATUS, 1'b1, 32'd0, rd);
            // Sent count is n in a counted run and the seen count in a continuous one
            bus_read(pkt_gen_pkg::REG_SENT, 1'b1, cont_mode ? frames_seen : n, rd);
            bus_read(pkt_gen_pkg::REG_REMAINING, 1'b1, 32'd0, rd);
            strobe_marker(1'b1);
            ready_mode = 0;
        end

        repeat (4) @(posedge clk_ifc_avmm);
        $display("Tests run %0d, passed %0d, failed %0d, errors %0d",
                 n_tests, tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
